// File: dv/tb_vout.sv
module tb_vout;

  import vout_pkg::*;

  // One line of the stimulus file
  typedef struct packed {
    logic [CFG_W-1:0]     cfg;
    logic                 pal;
    logic                 pll;
    logic                 vga;
    logic                 valid;
    vdata_t               pix;
    logic [3*COLOR_W-1:0] exp_vd;
    logic [1:0]           exp_ncs;
    logic                 exp_f2;
    logic                 exp_f1;
    logic [LM_W-1:0]      exp_sel;
    ppu_state_t           exp_state;
  } vec_t;

  // Expected results travelling alongside the DUT pipeline
  typedef struct packed {
    logic                 act;
    logic                 pix;
    logic [3*COLOR_W-1:0] vd;
    logic [1:0]           ncs;
    logic                 f2;
    logic                 f1;
    logic [LM_W-1:0]      sel;
    ppu_state_t           state;
  } slot_t;

  logic                 VCLK_Tx;
  logic                 nVRST_Tx;
  logic [CFG_W-1:0]     config_i;
  logic                 pal_mode_i;
  logic                 pll_locked_i;
  logic                 use_vga_hvsync_i;
  logic                 vdata_valid_i;
  vdata_t               vdata_i;
  logic [3*COLOR_W-1:0] vd_o;
  logic [1:0]           ncsync_o;
  logic                 nvsync_or_f2_o;
  logic                 nhsync_or_f1_o;
  logic [LM_W-1:0]      vclk_tx_select_o;
  ppu_state_t           ppu_state_o;

  vec_t  vecs[$];
  int    num_vec;
  logic  load_done;
  slot_t slot_in;
  slot_t dly [3];

  vout_clk_gen u_clk_gen (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx)
  );

  vout_top u_vout_top (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .config_i         (config_i),
    .pal_mode_i       (pal_mode_i),
    .pll_locked_i     (pll_locked_i),
    .use_vga_hvsync_i (use_vga_hvsync_i),
    .vdata_valid_i    (vdata_valid_i),
    .vdata_i          (vdata_i),
    .vd_o             (vd_o),
    .ncsync_o         (ncsync_o),
    .nvsync_or_f2_o   (nvsync_or_f2_o),
    .nhsync_or_f1_o   (nhsync_or_f1_o),
    .vclk_tx_select_o (vclk_tx_select_o),
    .ppu_state_o      (ppu_state_o)
  );

  // ==========================================================
  // Failure and compare tasks
  // ==========================================================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_vd(input logic [3*COLOR_W-1:0] act, input logic [3*COLOR_W-1:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("mismatch at %0t: vd_o got %h expected %h", $time, act, exp));
    end
  endtask

  // Composite sync pair plus the two shared pins
  task automatic check_sync(input logic [1:0] act_ncs, input logic act_f2, input logic act_f1,
                            input logic [1:0] exp_ncs, input logic exp_f2, input logic exp_f1);
    if (act_ncs !== exp_ncs) begin
      abort_run($sformatf("mismatch at %0t: ncsync_o got %b expected %b",
                          $time, act_ncs, exp_ncs));
    end
    if (act_f2 !== exp_f2) begin
      abort_run($sformatf("mismatch at %0t: nvsync_or_f2_o got %b expected %b",
                          $time, act_f2, exp_f2));
    end
    if (act_f1 !== exp_f1) begin
      abort_run($sformatf("mismatch at %0t: nhsync_or_f1_o got %b expected %b",
                          $time, act_f1, exp_f1));
    end
  endtask

  task automatic check_state(input ppu_state_t act, input ppu_state_t exp);
    if (act !== exp) begin
      abort_run($sformatf("mismatch at %0t: ppu_state_o got %h expected %h", $time, act, exp));
    end
  endtask

  task automatic check_select(input logic [LM_W-1:0] act, input logic [LM_W-1:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("mismatch at %0t: vclk_tx_select_o got %h expected %h",
                          $time, act, exp));
    end
  endtask

  // ==========================================================
  // Stimulus file
  // ==========================================================

  task automatic load_vectors();
    int          fd;
    int          cnt;
    int          line_no;
    string       line;
    logic [31:0] f_cfg;
    logic [31:0] f_pal;
    logic [31:0] f_pll;
    logic [31:0] f_vga;
    logic [31:0] f_vld;
    logic [31:0] f_pix;
    logic [31:0] f_vd;
    logic [31:0] f_ncs;
    logic [31:0] f_f2;
    logic [31:0] f_f1;
    logic [31:0] f_sel;
    logic [31:0] f_st;
    vec_t        v;
    line_no = 0;
    fd = $fopen("dv/vout_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open stimulus file dv/vout_stimulus.txt");
    end
    while ($fgets(line, fd) > 0) begin
      line_no++;
      // Comment lines start with a hash
      if (line.len() == 0 || line.getc(0) == 8'h23) begin
        continue;
      end
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                    f_cfg, f_pal, f_pll, f_vga, f_vld, f_pix,
                    f_vd, f_ncs, f_f2, f_f1, f_sel, f_st);
      if (cnt <= 0) begin
        continue;
      end
      if (cnt != 12) begin
        abort_run($sformatf("stimulus line %0d holds %0d fields instead of 12", line_no, cnt));
      end
      v.cfg = f_cfg[CFG_W-1:0];
      v.pal = f_pal[0];
      v.pll = f_pll[0];
      v.vga = f_vga[0];
      v.valid = f_vld[0];
      v.pix = f_pix[SYNC_W+3*COLOR_W-1:0];
      v.exp_vd = f_vd[3*COLOR_W-1:0];
      v.exp_ncs = f_ncs[1:0];
      v.exp_f2 = f_f2[0];
      v.exp_f1 = f_f1[0];
      v.exp_sel = f_sel[LM_W-1:0];
      v.exp_state = f_st[7:0];
      vecs.push_back(v);
    end
    $fclose(fd);
    num_vec = vecs.size();
    if (num_vec == 0) begin
      abort_run("stimulus file holds no test vectors");
    end
  endtask

  // ==========================================================
  // Drivers
  // ==========================================================

  // Inputs that force a pipeline drain when they change
  function automatic logic [CFG_W+2:0] cfg_key(input vec_t v);
    return {v.cfg, v.pal, v.pll, v.vga};
  endfunction

  // Expected outputs of a vector, pixel part only when a pixel goes in
  function automatic slot_t expected_outputs(input vec_t v, input logic with_pix);
    slot_t s;
    s.act = 1'b1;
    s.pix = with_pix && v.valid;
    s.vd = v.exp_vd;
    s.ncs = v.exp_ncs;
    s.f2 = v.exp_f2;
    s.f1 = v.exp_f1;
    s.sel = v.exp_sel;
    s.state = v.exp_state;
    return s;
  endfunction

  task automatic drive_idle();
    @(posedge VCLK_Tx);
    vdata_valid_i <= 1'b0;
    slot_in <= '0;
  endtask

  task automatic drive_config(input vec_t v);
    @(posedge VCLK_Tx);
    config_i <= v.cfg;
    pal_mode_i <= v.pal;
    pll_locked_i <= v.pll;
    use_vga_hvsync_i <= v.vga;
    vdata_valid_i <= 1'b0;
    slot_in <= expected_outputs(v, 1'b0);
  endtask

  task automatic drive_vector(input vec_t v);
    @(posedge VCLK_Tx);
    vdata_valid_i <= v.valid;
    vdata_i <= v.pix;
    slot_in <= expected_outputs(v, 1'b1);
  endtask

  // ==========================================================
  // Checker behind the driver
  // ==========================================================

  always @(negedge VCLK_Tx) begin
    // Config outputs settle two cycles after the drive edge
    if (dly[1].act) begin
      check_state(ppu_state_o, dly[1].state);
      check_select(vclk_tx_select_o, dly[1].sel);
    end
    // Pixel outputs three cycles after the drive edge
    if (dly[2].pix) begin
      check_vd(vd_o, dly[2].vd);
      check_sync(ncsync_o, nvsync_or_f2_o, nhsync_or_f1_o, dly[2].ncs, dly[2].f2, dly[2].f1);
    end
    dly[2] = dly[1];
    dly[1] = dly[0];
    dly[0] = slot_in;
  end

  // Watchdog sized from the vector count
  initial begin
    wait (load_done === 1'b1);
    repeat (num_vec * 8 + 100) @(posedge VCLK_Tx);
    abort_run($sformatf("watchdog expired after %0d cycles", num_vec * 8 + 100));
  end

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial begin
    int gap;
    config_i = '0;
    pal_mode_i = 1'b0;
    pll_locked_i = 1'b0;
    use_vga_hvsync_i = 1'b0;
    vdata_valid_i = 1'b0;
    vdata_i = '0;
    slot_in = '0;
    dly[0] = '0;
    dly[1] = '0;
    dly[2] = '0;
    load_done = 1'b0;
    void'($urandom(32'h3867));
    load_vectors();
    load_done = 1'b1;

    // Outputs start at zero
    wait (nVRST_Tx === 1'b1);
    @(negedge VCLK_Tx);
    check_vd(vd_o, '0);
    check_sync(ncsync_o, nvsync_or_f2_o, nhsync_or_f1_o, 2'b00, 1'b0, 1'b0);
    check_select(vclk_tx_select_o, '0);
    check_state(ppu_state_o, '0);

    for (int i = 0; i < num_vec; i++) begin
      // New config waits for an empty pipeline and one settling cycle
      if (i == 0 || cfg_key(vecs[i]) != cfg_key(vecs[i-1])) begin
        gap = $urandom % 3;
        repeat (4 + gap) drive_idle();
        drive_config(vecs[i]);
        drive_idle();
      end
      // Same config runs back to back
      drive_vector(vecs[i]);
    end
    repeat (6) drive_idle();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: dv/vout_clk_gen.sv
module vout_clk_gen (
  output logic VCLK_Tx,
  output logic nVRST_Tx
);

  // Transmit clock, 20 units per period
  initial begin
    VCLK_Tx = 1'b0;
    forever begin
      #10 VCLK_Tx = ~VCLK_Tx;
    end
  end

  // Reset low for the first 4 rising edges
  initial begin
    nVRST_Tx = 1'b0;
    repeat (4) @(posedge VCLK_Tx);
    nVRST_Tx <= 1'b1;
  end

endmodule

// File: dv/vout_stimulus.txt
# cfg pal pll vga valid vin exp_vd exp_ncsync exp_f2 exp_f1 exp_select exp_state
# vin holds the sync nibble then c0 c1 c2, exp_state is the ppu_state_t byte
0000 0 1 0 1 f123456 123456 2 0 0 0 01
0000 0 1 0 1 eabcdef abcdef 0 0 0 0 01
8000 0 1 0 1 f112233 332211 2 0 0 0 01
8000 0 1 0 1 fff0080 8000ff 2 0 0 0 01
0800 0 1 0 1 fff0000 4c55ff 3 0 0 0 11
0800 0 1 0 1 f00ff00 952b15 3 0 0 0 11
0800 0 1 0 1 f0000ff 1cff6b 3 0 0 0 11
0800 0 1 0 1 fffffff ff8080 3 0 0 0 11
0800 0 1 0 1 f000000 008080 3 0 0 0 11
0800 0 1 0 1 f808080 808080 3 0 0 0 11
0800 0 1 0 1 f00ffff b2aa00 3 0 0 0 11
0800 0 1 0 1 fffff00 e20094 3 0 0 0 11
8800 0 1 0 1 fff0000 ff554c 3 0 0 0 11
0400 0 1 0 1 e010203 010203 0 0 0 0 09
0400 0 1 0 1 f040506 040506 3 0 0 0 09
3100 0 1 0 1 f0a0b0c 0a0b0c 2 0 1 1 24
2100 0 1 0 1 f405060 405060 2 1 0 1 22
0200 0 1 0 1 f102030 102030 2 0 1 2 45
0300 0 1 0 1 f000000 000000 2 1 1 3 67
0300 1 1 0 1 f000000 000000 2 0 0 0 81
0300 0 0 0 1 f000000 000000 2 0 0 0 01
0000 0 1 1 1 a777777 777777 0 1 1 0 01
0000 0 1 1 1 5888888 888888 2 0 0 0 01
0000 0 1 1 0 0000000 000000 0 0 0 0 01

// File: hw/vout_cfg_decode.sv
module vout_cfg_decode (
  input  logic                       VCLK_Tx,
  input  logic                       nVRST_Tx,
  input  logic [vout_pkg::CFG_W-1:0] config_i,
  input  logic                       pal_mode_i,
  input  logic                       pll_locked_i,
  output vout_pkg::cfg_t             cfg_o,
  output logic [vout_pkg::LM_W-1:0]  vclk_tx_select_o
);

  import vout_pkg::*;

  cfg_t            cfg_d;
  cfg_t            cfg_q;
  logic [LM_W-1:0] lm_raw;
  logic            lm_limit;

  // ==========================================================
  // Field extraction
  // ==========================================================

  assign lm_raw = config_i[CFG_LINEMULT_MSB:CFG_LINEMULT_LSB];

  // LineX3 needs NTSC timing and a locked transmit PLL
  assign lm_limit = pal_mode_i || !pll_locked_i;

  always_comb begin
    cfg_d.exchange_rb = config_i[CFG_EXCHANGE_RB_BIT];
    cfg_d.filter = config_i[CFG_FILTER_MSB:CFG_FILTER_LSB];
    cfg_d.ypbpr_en = config_i[CFG_YPBPR_BIT];
    cfg_d.rgsb_en = config_i[CFG_RGSB_BIT];

    // Only the x3 code is restricted
    case (lm_raw)
      LM_OFF, LM_X2, LM_X2_ALT: begin
        cfg_d.linemult = lm_raw;
      end
      LM_X3: begin
        cfg_d.linemult = lm_limit ? LM_OFF : LM_X3;
      end
      default: begin
        cfg_d.linemult = LM_OFF;
      end
    endcase
  end

  // ==========================================================
  // Configuration register
  // ==========================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_q <= '0;
    end else begin
      cfg_q <= cfg_d;
    end
  end

  assign cfg_o = cfg_q;

  // Transmit clock select follows the limited line multiplier
  assign vclk_tx_select_o = cfg_q.linemult;

  // PAL in the previous cycle must never leave LineX3 selected
  a_no_x3_in_pal: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    $past(pal_mode_i) |-> (cfg_o.linemult != LM_X3)
  );

endmodule

// File: hw/vout_color_conv.sv
module vout_color_conv (
  input  logic             VCLK_Tx,
  input  logic             nVRST_Tx,
  input  logic             ypbpr_en_i,
  input  logic             vdata_valid_i,
  input  vout_pkg::vdata_t vdata_i,
  output logic             vdata_valid_o,
  output vout_pkg::vdata_t vdata_o
);

  import vout_pkg::*;

  // Product order: Y (r,g,b), Pb (r,g,b), Pr (r,g,b)
  logic signed [PROD_W-1:0] prod_d [9];
  logic signed [PROD_W-1:0] prod_q [9];
  logic                     valid_s1;
  logic                     ypbpr_s1;
  vdata_t                   raw_s1;
  logic signed [SUM_W-1:0]  sum_y;
  logic signed [SUM_W-1:0]  sum_pb;
  logic signed [SUM_W-1:0]  sum_pr;
  vdata_t                   conv_d;

  // Unsigned component times signed coefficient
  function automatic logic signed [PROD_W-1:0] mul_coef(
    input logic [COLOR_W-1:0] c,
    input int                 coef
  );
    mul_coef = PROD_W'($signed({1'b0, c}) * coef);
  endfunction

  // Scaled value into 0..255
  function automatic logic [COLOR_W-1:0] clamp_color(input logic signed [SUM_W-1:0] v);
    logic [COLOR_W-1:0] res;
    if (v < 0) begin
      res = '0;
    end else if (v > COLOR_MAX) begin
      res = '1;
    end else begin
      res = v[COLOR_W-1:0];
    end
    return res;
  endfunction

  // ==========================================================
  // Stage 1, coefficient products
  // ==========================================================

  always_comb begin
    prod_d[0] = mul_coef(vdata_i.c0, Y_CR);
    prod_d[1] = mul_coef(vdata_i.c1, Y_CG);
    prod_d[2] = mul_coef(vdata_i.c2, Y_CB);
    prod_d[3] = mul_coef(vdata_i.c0, PB_CR);
    prod_d[4] = mul_coef(vdata_i.c1, PB_CG);
    prod_d[5] = mul_coef(vdata_i.c2, PB_CB);
    prod_d[6] = mul_coef(vdata_i.c0, PR_CR);
    prod_d[7] = mul_coef(vdata_i.c1, PR_CG);
    prod_d[8] = mul_coef(vdata_i.c2, PR_CB);
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= vdata_valid_i;
    end
  end

  // Enable travels with its own pixel
  always_ff @(posedge VCLK_Tx) begin
    if (vdata_valid_i) begin
      prod_q <= prod_d;
      ypbpr_s1 <= ypbpr_en_i;
      raw_s1 <= vdata_i;
    end
  end

  // ==========================================================
  // Stage 2, sum, offset, floor and clamp
  // ==========================================================

  // Arithmetic shift floors toward minus infinity
  always_comb begin
    sum_y = (SUM_W'(prod_q[0]) + SUM_W'(prod_q[1]) + SUM_W'(prod_q[2])) >>> COEF_SHIFT;
    sum_pb = (SUM_W'(prod_q[3]) + SUM_W'(prod_q[4]) + SUM_W'(prod_q[5])
              + SUM_W'(CHROMA_OFFSET << COEF_SHIFT)) >>> COEF_SHIFT;
    sum_pr = (SUM_W'(prod_q[6]) + SUM_W'(prod_q[7]) + SUM_W'(prod_q[8])
              + SUM_W'(CHROMA_OFFSET << COEF_SHIFT)) >>> COEF_SHIFT;

    // Sync passes unchanged in both modes
    conv_d = raw_s1;
    if (ypbpr_s1) begin
      conv_d.c0 = clamp_color(sum_y);
      conv_d.c1 = clamp_color(sum_pb);
      conv_d.c2 = clamp_color(sum_pr);
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vdata_valid_o <= 1'b0;
    end else begin
      vdata_valid_o <= valid_s1;
    end
  end

  always_ff @(posedge VCLK_Tx) begin
    if (valid_s1) begin
      vdata_o <= conv_d;
    end
  end

  // Fixed two cycle latency through the pipeline
  a_valid_latency: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    $past(nVRST_Tx, 2) |-> (vdata_valid_o == $past(vdata_valid_i, 2))
  );

endmodule

// File: hw/vout_out_stage.sv
module vout_out_stage (
  input  logic                           VCLK_Tx,
  input  logic                           nVRST_Tx,
  input  vout_pkg::cfg_t                 cfg_i,
  input  logic                           pal_mode_i,
  input  logic                           use_vga_hvsync_i,
  input  logic                           vdata_valid_i,
  input  vout_pkg::vdata_t               vdata_i,
  output logic [3*vout_pkg::COLOR_W-1:0] vd_o,
  output logic [1:0]                     ncsync_o,
  output logic                           nvsync_or_f2_o,
  output logic                           nhsync_or_f1_o,
  output vout_pkg::ppu_state_t           ppu_state_o
);

  import vout_pkg::*;

  logic [FILTER_W-1:0] filter_m1;
  logic                auto_d;
  logic [FSEL_W-1:0]   sel_d;
  logic [FSEL_W-1:0]   filter_sel_q;
  logic                auto_q;
  logic                csync_off;

  // ==========================================================
  // Pixel and composite sync
  // ==========================================================

  // Second csync pin stays low for plain RGB with separate syncs
  assign csync_off = !cfg_i.ypbpr_en && !cfg_i.rgsb_en;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_o <= '0;
      ncsync_o <= 2'b00;
    end else if (vdata_valid_i) begin
      // Red and blue swap for boards with crossed DAC channels
      if (cfg_i.exchange_rb) begin
        vd_o <= {vdata_i.c2, vdata_i.c1, vdata_i.c0};
      end else begin
        vd_o <= {vdata_i.c0, vdata_i.c1, vdata_i.c2};
      end
      ncsync_o[1] <= vdata_i.sync[SYNC_NCSYNC];
      ncsync_o[0] <= csync_off ? 1'b0 : vdata_i.sync[SYNC_NCSYNC];
    end
  end

  // ==========================================================
  // Filter add-on select
  // ==========================================================

  // Setting 0 is auto, which tracks the line multiplier
  // Other settings pick a fixed cutoff, setting minus one
  assign auto_d = (cfg_i.filter == '0);
  assign filter_m1 = cfg_i.filter - FILTER_W'(1);
  assign sel_d = auto_d ? cfg_i.linemult : filter_m1[FSEL_W-1:0];

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      filter_sel_q <= '0;
      auto_q <= 1'b0;
    end else begin
      filter_sel_q <= sel_d;
      auto_q <= auto_d;
    end
  end

  // Shared pins, VGA syncs or filter select
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      nvsync_or_f2_o <= 1'b0;
      nhsync_or_f1_o <= 1'b0;
    end else if (use_vga_hvsync_i) begin
      // Syncs stay aligned with the pixel on vd_o
      if (vdata_valid_i) begin
        nvsync_or_f2_o <= vdata_i.sync[SYNC_NVSYNC];
        nhsync_or_f1_o <= vdata_i.sync[SYNC_NHSYNC];
      end
    end else begin
      nvsync_or_f2_o <= sel_d[0];
      nhsync_or_f1_o <= sel_d[1];
    end
  end

  // ==========================================================
  // Status word
  // ==========================================================

  assign ppu_state_o = '{
    pal_mode:    pal_mode_i,
    linemult:    cfg_i.linemult,
    ypbpr_en:    cfg_i.ypbpr_en,
    rgsb_en:     cfg_i.rgsb_en,
    filter_sel:  filter_sel_q,
    auto_filter: auto_q
  };

  // In VGA mode the pins only move with a pixel strobe
  a_vga_pins_hold: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    ($past(use_vga_hvsync_i) && !$past(vdata_valid_i))
      |-> $stable({nvsync_or_f2_o, nhsync_or_f1_o})
  );

endmodule

// File: hw/vout_pkg.sv
package vout_pkg;

  // ==========================================================
  // Widths
  // ==========================================================

  // One colour component
  localparam int COLOR_W = 8;
  localparam int COLOR_MAX = (1 << COLOR_W) - 1;

  // Sync bundle, MSB first: nvsync, nclamp, nhsync, ncsync
  localparam int SYNC_W = 4;
  localparam int SYNC_NVSYNC = 3;
  localparam int SYNC_NHSYNC = 1;
  localparam int SYNC_NCSYNC = 0;

  // Reduced configuration word
  localparam int CFG_W = 16;

  // Line multiplier code, filter setting and filter select
  localparam int LM_W = 2;
  localparam int FILTER_W = 3;
  localparam int FSEL_W = 2;

  // ==========================================================
  // Configuration word layout
  // ==========================================================

  localparam int CFG_EXCHANGE_RB_BIT = 15;
  localparam int CFG_FILTER_MSB = 14;
  localparam int CFG_FILTER_LSB = 12;
  localparam int CFG_YPBPR_BIT = 11;
  localparam int CFG_RGSB_BIT = 10;
  localparam int CFG_LINEMULT_MSB = 9;
  localparam int CFG_LINEMULT_LSB = 8;
  // Bits 7 to 0 reserved

  // Line multiplier codes
  localparam logic [LM_W-1:0] LM_OFF = 2'd0;
  localparam logic [LM_W-1:0] LM_X2 = 2'd1;
  localparam logic [LM_W-1:0] LM_X2_ALT = 2'd2;
  localparam logic [LM_W-1:0] LM_X3 = 2'd3;

  // ==========================================================
  // RGB to YPbPr coefficients, units of 1/256
  // ==========================================================

  localparam int COEF_SHIFT = 8;
  localparam int Y_CR = 77;
  localparam int Y_CG = 150;
  localparam int Y_CB = 29;
  localparam int PB_CR = -43;
  localparam int PB_CG = -85;
  localparam int PB_CB = 128;
  localparam int PR_CR = 128;
  localparam int PR_CG = -107;
  localparam int PR_CB = -21;
  // Chroma midpoint, added after scaling
  localparam int CHROMA_OFFSET = 128;

  // Product and sum widths, signed
  localparam int PROD_W = 18;
  localparam int SUM_W = 20;

  // Pixel with sync, components are R G B or Y Pb Pr
  typedef struct packed {
    logic [SYNC_W-1:0]  sync;
    logic [COLOR_W-1:0] c0;
    logic [COLOR_W-1:0] c1;
    logic [COLOR_W-1:0] c2;
  } vdata_t;

  // Decoded configuration
  typedef struct packed {
    logic                exchange_rb;
    logic [FILTER_W-1:0] filter;
    logic                ypbpr_en;
    logic                rgsb_en;
    logic [LM_W-1:0]     linemult;
  } cfg_t;

  // Status word
  typedef struct packed {
    logic              pal_mode;
    logic [LM_W-1:0]   linemult;
    logic              ypbpr_en;
    logic              rgsb_en;
    logic [FSEL_W-1:0] filter_sel;
    logic              auto_filter;
  } ppu_state_t;

endpackage

// File: hw/vout_top.sv
module vout_top (
  input  logic                           VCLK_Tx,
  input  logic                           nVRST_Tx,
  input  logic [vout_pkg::CFG_W-1:0]     config_i,
  input  logic                           pal_mode_i,
  input  logic                           pll_locked_i,
  input  logic                           use_vga_hvsync_i,
  input  logic                           vdata_valid_i,
  input  vout_pkg::vdata_t               vdata_i,
  output logic [3*vout_pkg::COLOR_W-1:0] vd_o,
  output logic [1:0]                     ncsync_o,
  output logic                           nvsync_or_f2_o,
  output logic                           nhsync_or_f1_o,
  output logic [vout_pkg::LM_W-1:0]      vclk_tx_select_o,
  output vout_pkg::ppu_state_t           ppu_state_o
);

  import vout_pkg::*;

  cfg_t   cfg;
  logic   conv_valid;
  vdata_t conv_data;

  // ==========================================================
  // Decode, configuration word to cfg
  // ==========================================================

  vout_cfg_decode u_cfg_decode (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .config_i         (config_i),
    .pal_mode_i       (pal_mode_i),
    .pll_locked_i     (pll_locked_i),
    .cfg_o            (cfg),
    .vclk_tx_select_o (vclk_tx_select_o)
  );

  // ==========================================================
  // Execute, colour space conversion
  // ==========================================================

  vout_color_conv u_color_conv (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .ypbpr_en_i    (cfg.ypbpr_en),
    .vdata_valid_i (vdata_valid_i),
    .vdata_i       (vdata_i),
    .vdata_valid_o (conv_valid),
    .vdata_o       (conv_data)
  );

  // ==========================================================
  // Result, pins and status
  // ==========================================================

  vout_out_stage u_out_stage (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .cfg_i            (cfg),
    .pal_mode_i       (pal_mode_i),
    .use_vga_hvsync_i (use_vga_hvsync_i),
    .vdata_valid_i    (conv_valid),
    .vdata_i          (conv_data),
    .vd_o             (vd_o),
    .ncsync_o         (ncsync_o),
    .nvsync_or_f2_o   (nvsync_or_f2_o),
    .nhsync_or_f1_o   (nhsync_or_f1_o),
    .ppu_state_o      (ppu_state_o)
  );

endmodule

// File: run_sim.sh
#!/bin/bash
# Build with Verilator, run, and decide from the simulation log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_vout -f verilog.f -o tb_vout_sim \
  && ./obj_dir/tb_vout_sim > sim.log 2>&1 \
  || echo "build or run ended with an error"
cat sim.log 2>/dev/null
grep -q "^TEST RESULT: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: verilog.f
hw/vout_pkg.sv
hw/vout_cfg_decode.sv
hw/vout_color_conv.sv
hw/vout_out_stage.sv
hw/vout_top.sv
dv/vout_clk_gen.sv
dv/tb_vout.sv
